// File: hw/ext_mem_pkg.sv
package ext_mem_pkg;

  localparam int BUS_ADDR_W = 24;
  localparam int BUS_DATA_W = 32;
  localparam int BUS_BE_W   = BUS_DATA_W / 8;
  localparam int DEV_ADDR_W = 22;
  localparam int FLASH_W    = 16;
  localparam int SRAM_W     = 32;

  // default access lengths in bus cycles, handed down by the top level.
  localparam int FLASH_CYCLES = 3;
  localparam int SRAM_CYCLES  = 2;

  typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
  typedef logic [BUS_DATA_W-1:0] bus_data_t;
  typedef logic [BUS_BE_W-1:0]   bus_be_t;
  typedef logic [DEV_ADDR_W-1:0] dev_addr_t;
  typedef logic [FLASH_W-1:0]    flash_half_t;
  typedef logic [SRAM_W-1:0]     sram_word_t;

  typedef struct packed {
    bus_addr_t address;  // byte address.
    bus_data_t data;
    bus_be_t   be;
    logic      read;
    logic      write;
  } bus_req_t;

  typedef struct packed {
    bus_data_t data;
    logic      stall;
  } bus_rsp_t;

  typedef struct packed {
    dev_addr_t address;  // device word address.
    logic      we_n;
    logic      oe_n;
    logic      ce_n;
  } dev_ctrl_t;

endpackage

// File: hw/parallel_ifce.sv
`timescale 1ns/10ps

module parallel_ifce #(
  parameter int  rw_bus_cycle = 2,
  parameter type data_t       = ext_mem_pkg::sram_word_t
) (
  input  logic                   clk_bus,
  input  logic                   rst_n,
  input  ext_mem_pkg::dev_addr_t address_i,
  input  data_t                  data_i,
  input  logic                   read_i,
  input  logic                   write_i,
  output data_t                  data_o,
  output logic                   stall_o,
  output ext_mem_pkg::dev_ctrl_t dev_ctrl_o,
  input  data_t                  dev_data_i,
  output data_t                  dev_data_o,
  output logic                   dev_data_t_o
);

  // a single cycle access still needs a one bit counter.
  localparam int cnt_w = (rw_bus_cycle > 1) ? $clog2(rw_bus_cycle) : 1;
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(rw_bus_cycle - 1);

  logic             access;
  logic             last_cycle;
  logic [cnt_w-1:0] cycle_cnt;

  assign access     = read_i | write_i;
  assign last_cycle = (cycle_cnt == last_cnt);

  // cycle_cnt holds the number of cycles already spent on the access.
  always_ff @(posedge clk_bus or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
    end else if (access && !last_cycle) begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end else begin
      cycle_cnt <= '0;  // cleared after completion or when idle.
    end
  end

  // the bus holds its strobe until completion, so the pins follow it directly.
  always_comb begin
    dev_ctrl_o.address = address_i;
    dev_ctrl_o.we_n    = ~write_i;
    dev_ctrl_o.oe_n    = ~read_i;
    dev_ctrl_o.ce_n    = ~access;
  end

  assign stall_o = access & ~last_cycle;

  // read data is only presented in the cycle that completes the access.
  always_comb begin
    if (read_i && last_cycle) begin
      data_o = dev_data_i;
    end else begin
      data_o = '0;
    end
  end

  assign dev_data_o   = data_i;
  assign dev_data_t_o = ~write_i;  // pins are driven only while writing.

endmodule

// File: hw/flash_top.sv
`timescale 1ns/10ps

module flash_top #(
  parameter int rw_bus_cycle = ext_mem_pkg::FLASH_CYCLES
) (
  input  logic                   clk_bus,
  input  logic                   rst_n,
  input  ext_mem_pkg::bus_req_t  req_i,
  output ext_mem_pkg::bus_rsp_t  rsp_o,
  output ext_mem_pkg::dev_ctrl_t flash_ctrl_o,
  inout  wire [15:0]             flash_data_io,
  output logic                   flash_byte_n_o,
  output logic                   flash_rp_n_o,
  output logic                   flash_vpen_o,
  output logic [2:0]             flash_ce_o
);

  import ext_mem_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_lo_pend,
    st_hi_pend
  } wait_state_t;

  wait_state_t wait_state;
  logic        word_read;
  logic        hi_phase;
  logic        upper_half;
  logic        ifce_stall;
  logic        lower_done;
  logic        pin_data_t;
  flash_half_t wr_half;
  flash_half_t rd_half;
  flash_half_t lower_buf;
  flash_half_t pin_data_out;

  assign word_read  = req_i.read & (&req_i.be);
  assign hi_phase   = (wait_state == st_hi_pend);
  assign upper_half = hi_phase | ~(|req_i.be[1:0]);
  assign wr_half    = upper_half ? req_i.data[31:16] : req_i.data[15:0];
  assign lower_done = word_read & ~hi_phase & ~ifce_stall;

  // a word read runs the lower half first, then the upper half.
  always_ff @(posedge clk_bus or negedge rst_n) begin
    if (!rst_n) begin
      wait_state <= st_idle;
    end else begin
      case (wait_state)
        st_idle: begin
          if (word_read) begin
            wait_state <= ifce_stall ? st_lo_pend : st_hi_pend;
          end
        end
        st_lo_pend: begin
          if (!ifce_stall) begin
            wait_state <= st_hi_pend;
          end
        end
        st_hi_pend: begin
          if (!ifce_stall) begin
            wait_state <= st_idle;
          end
        end
        default: wait_state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk_bus) begin
    if (lower_done) begin
      lower_buf <= rd_half;
    end
  end

  always_comb begin
    rsp_o.data  = hi_phase ? {rd_half, lower_buf} : {2{rd_half}};
    rsp_o.stall = ifce_stall | (word_read & ~hi_phase);  // hides the lower half.
  end

  parallel_ifce #(
    .rw_bus_cycle (rw_bus_cycle),
    .data_t       (flash_half_t)
  ) u_flash_ifce (
    .clk_bus      (clk_bus),
    .rst_n        (rst_n),
    .address_i    ({req_i.address[22:2], upper_half}),
    .data_i       (wr_half),
    .read_i       (req_i.read),
    .write_i      (req_i.write),
    .data_o       (rd_half),
    .stall_o      (ifce_stall),
    .dev_ctrl_o   (flash_ctrl_o),
    .dev_data_i   (flash_data_io),
    .dev_data_o   (pin_data_out),
    .dev_data_t_o (pin_data_t)
  );

  assign flash_data_io  = pin_data_t ? {16{1'bz}} : pin_data_out;
  assign flash_rp_n_o   = rst_n;  // flash is held in reset with the bus.
  assign flash_byte_n_o = 1'b1;
  assign flash_vpen_o   = 1'b1;
  assign flash_ce_o     = 3'b000;

endmodule

// File: hw/bus_decode.sv
`timescale 1ns/10ps

module bus_decode (
  input  ext_mem_pkg::bus_req_t req_i,
  output ext_mem_pkg::bus_req_t flash_req_o,
  output ext_mem_pkg::bus_req_t sram_req_o,
  input  ext_mem_pkg::bus_rsp_t flash_rsp_i,
  input  ext_mem_pkg::bus_rsp_t sram_rsp_i,
  output ext_mem_pkg::bus_rsp_t rsp_o
);

  import ext_mem_pkg::*;

  // the top address bit picks the device.
  localparam int sel_bit = BUS_ADDR_W - 1;

  logic sram_sel;

  assign sram_sel = req_i.address[sel_bit];

  always_comb begin
    flash_req_o       = req_i;
    flash_req_o.read  = req_i.read & ~sram_sel;
    flash_req_o.write = req_i.write & ~sram_sel;

    sram_req_o        = req_i;
    sram_req_o.read   = req_i.read & sram_sel;
    sram_req_o.write  = req_i.write & sram_sel;
  end

  // the address is held for the whole transfer, so it also steers the response.
  always_comb begin
    if (sram_sel) begin
      rsp_o = sram_rsp_i;
    end else begin
      rsp_o = flash_rsp_i;
    end
  end

endmodule

// File: hw/ext_mem_top.sv
`timescale 1ns/10ps

module ext_mem_top #(
  parameter int flash_cycles = ext_mem_pkg::FLASH_CYCLES,
  parameter int sram_cycles  = ext_mem_pkg::SRAM_CYCLES
) (
  input  logic                   clk_bus,
  input  logic                   rst_n,
  input  ext_mem_pkg::bus_req_t  bus_req_i,
  output ext_mem_pkg::bus_rsp_t  bus_rsp_o,
  output ext_mem_pkg::dev_ctrl_t flash_ctrl_o,
  inout  wire [15:0]             flash_data_io,
  output logic                   flash_byte_n_o,
  output logic                   flash_rp_n_o,
  output logic                   flash_vpen_o,
  output logic [2:0]             flash_ce_o,
  output ext_mem_pkg::dev_ctrl_t sram_ctrl_o,
  inout  wire [31:0]             sram_data_io
);

  import ext_mem_pkg::*;

  bus_req_t   flash_req;
  bus_req_t   sram_req;
  bus_rsp_t   flash_rsp;
  bus_rsp_t   sram_rsp;
  sram_word_t sram_data_out;
  logic       sram_data_t;

  bus_decode u_bus_decode (
    .req_i       (bus_req_i),
    .flash_req_o (flash_req),
    .sram_req_o  (sram_req),
    .flash_rsp_i (flash_rsp),
    .sram_rsp_i  (sram_rsp),
    .rsp_o       (bus_rsp_o)
  );

  flash_top #(
    .rw_bus_cycle   (flash_cycles)
  ) u_flash_top (
    .clk_bus        (clk_bus),
    .rst_n          (rst_n),
    .req_i          (flash_req),
    .rsp_o          (flash_rsp),
    .flash_ctrl_o   (flash_ctrl_o),
    .flash_data_io  (flash_data_io),
    .flash_byte_n_o (flash_byte_n_o),
    .flash_rp_n_o   (flash_rp_n_o),
    .flash_vpen_o   (flash_vpen_o),
    .flash_ce_o     (flash_ce_o)
  );

  // the sram is word wide, so the byte offset and select bit are dropped.
  parallel_ifce #(
    .rw_bus_cycle (sram_cycles),
    .data_t       (sram_word_t)
  ) u_sram_ifce (
    .clk_bus      (clk_bus),
    .rst_n        (rst_n),
    .address_i    ({1'b0, sram_req.address[22:2]}),
    .data_i       (sram_req.data),
    .read_i       (sram_req.read),
    .write_i      (sram_req.write),
    .data_o       (sram_rsp.data),
    .stall_o      (sram_rsp.stall),
    .dev_ctrl_o   (sram_ctrl_o),
    .dev_data_i   (sram_data_io),
    .dev_data_o   (sram_data_out),
    .dev_data_t_o (sram_data_t)
  );

  assign sram_data_io = sram_data_t ? {32{1'bz}} : sram_data_out;

endmodule

// File: bench/mem_models.sv
`timescale 1ns/10ps

module flash_model (
  input  logic                   clk_bus,
  input  ext_mem_pkg::dev_ctrl_t ctrl_i,
  inout  wire [15:0]             data_io
);

  logic [15:0] mem [0:2047];
  logic [10:0] wr_addr;
  logic [15:0] wr_data;

  // the write is latched while we_n is low and lands in the array when it rises.
  always @(posedge clk_bus) begin
    if (!ctrl_i.we_n && !ctrl_i.ce_n) begin
      wr_addr <= ctrl_i.address[10:0];
      wr_data <= data_io;
    end
  end

  always @(posedge ctrl_i.we_n) begin
    mem[wr_addr] <= wr_data;
  end

  assign data_io = (!ctrl_i.oe_n && !ctrl_i.ce_n) ? mem[ctrl_i.address[10:0]] : 'z;

endmodule

module sram_model (
  input  logic                   clk_bus,
  input  ext_mem_pkg::dev_ctrl_t ctrl_i,
  inout  wire [31:0]             data_io
);

  logic [31:0] mem [0:1023];
  logic [9:0]  wr_addr;
  logic [31:0] wr_data;

  always @(posedge clk_bus) begin
    if (!ctrl_i.we_n && !ctrl_i.ce_n) begin
      wr_addr <= ctrl_i.address[9:0];
      wr_data <= data_io;
    end
  end

  always @(posedge ctrl_i.we_n) begin
    mem[wr_addr] <= wr_data;
  end

  assign data_io = (!ctrl_i.oe_n && !ctrl_i.ce_n) ? mem[ctrl_i.address[9:0]] : 'z;

endmodule

// File: bench/tb_ext_mem.sv
`timescale 1ns/10ps

module tb_ext_mem;

  import ext_mem_pkg::*;

  localparam int n_words           = 16;
  localparam int max_wait          = 20;
  localparam int flash_half_cycles = 3;
  localparam int flash_word_cycles = 6;
  localparam int sram_cycles       = 2;

  logic        clk_bus = 1'b0;
  logic        rst_n;
  bus_req_t    bus_req;
  bus_rsp_t    bus_rsp;
  dev_ctrl_t   flash_ctrl;
  dev_ctrl_t   sram_ctrl;
  wire  [15:0] flash_data;
  wire  [31:0] sram_data;
  logic        flash_byte_n;
  logic        flash_rp_n;
  logic        flash_vpen;
  logic [2:0]  flash_ce;
  logic [2:0]  flash_strb;
  logic [2:0]  sram_strb;
  logic        flash_write;
  logic        sram_write;
  int          seed = 21;
  logic [9:0]  word_idx  [n_words];
  bus_data_t   flash_ref [n_words];
  bus_data_t   sram_ref  [n_words];

  ext_mem_top u_ext_mem_top (
    .clk_bus        (clk_bus),
    .rst_n          (rst_n),
    .bus_req_i      (bus_req),
    .bus_rsp_o      (bus_rsp),
    .flash_ctrl_o   (flash_ctrl),
    .flash_data_io  (flash_data),
    .flash_byte_n_o (flash_byte_n),
    .flash_rp_n_o   (flash_rp_n),
    .flash_vpen_o   (flash_vpen),
    .flash_ce_o     (flash_ce),
    .sram_ctrl_o    (sram_ctrl),
    .sram_data_io   (sram_data)
  );

  flash_model u_flash_model (.clk_bus(clk_bus), .ctrl_i(flash_ctrl), .data_io(flash_data));
  sram_model  u_sram_model  (.clk_bus(clk_bus), .ctrl_i(sram_ctrl), .data_io(sram_data));

  always #5 clk_bus = ~clk_bus;

  assign flash_strb  = {flash_ctrl.we_n, flash_ctrl.oe_n, flash_ctrl.ce_n};
  assign sram_strb   = {sram_ctrl.we_n, sram_ctrl.oe_n, sram_ctrl.ce_n};
  assign flash_write = bus_req.write & ~bus_req.address[23];
  assign sram_write  = bus_req.write & bus_req.address[23];

  task automatic stop_run();
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("FAILED %s expected %h actual %h", name, exp_val, act_val);
    stop_run();
  endtask

  task automatic report_error(input string msg);
    $display("ERROR %s", msg);
    stop_run();
  endtask

  assert property (@(posedge clk_bus) !(bus_req.read || bus_req.write) |->
                   {flash_strb, sram_strb} == 6'h3f)
    else report_mismatch("idle_strobes", 32'h3f, 32'({flash_strb, sram_strb}));
  assert property (@(posedge clk_bus) bus_req.address[23] |-> flash_strb == 3'b111)
    else report_mismatch("flash_strobes_on_sram", 32'h7, 32'(flash_strb));
  assert property (@(posedge clk_bus) !bus_req.address[23] |-> sram_strb == 3'b111)
    else report_mismatch("sram_strobes_on_flash", 32'h7, 32'(sram_strb));
  assert property (@(posedge clk_bus) {flash_byte_n, flash_vpen, flash_ce} == 5'b11000)
    else report_mismatch("fixed_flash_pins", 32'h18, 32'({flash_byte_n, flash_vpen, flash_ce}));
  assert property (@(posedge clk_bus) flash_rp_n == rst_n)
    else report_mismatch("flash_rp_n", 32'(rst_n), 32'(flash_rp_n));
  // the data pins are driven by the controller only while it writes.
  assert property (@(posedge clk_bus) u_ext_mem_top.u_flash_top.pin_data_t == !flash_write)
    else report_mismatch("flash_release", 32'(!flash_write),
                         32'(u_ext_mem_top.u_flash_top.pin_data_t));
  assert property (@(posedge clk_bus) u_ext_mem_top.sram_data_t == !sram_write)
    else report_mismatch("sram_release", 32'(!sram_write), 32'(u_ext_mem_top.sram_data_t));

  function automatic bus_req_t make_req(input logic sram, input int idx, input bus_be_t be,
                                        input bus_data_t data, input logic wr);
    bus_req_t req;
    req.address = {sram, 11'd0, word_idx[idx], 2'b00};
    req.data    = data;
    req.be      = be;
    req.read    = ~wr;
    req.write   = wr;
    return req;
  endfunction

  // holds one request until the first cycle without stall, then drops it.
  task automatic run_access(input string name, input bus_req_t req, input int exp_cycles,
                            output bus_data_t rd_data);
    int         cycles;
    int         low_cycles;
    logic [2:0] strb;
    @(negedge clk_bus);
    bus_req    = req;
    cycles     = 0;
    low_cycles = 0;
    do begin
      @(posedge clk_bus);
      cycles++;
      strb = req.address[23] ? sram_strb : flash_strb;
      if (((req.write && !strb[2]) || (req.read && !strb[1])) && !strb[0]) begin
        low_cycles++;
      end
      if (cycles > max_wait) begin
        report_error({name, " request never completed"});
      end
    end while (bus_rsp.stall);
    rd_data = bus_rsp.data;
    assert (cycles == exp_cycles)
      else report_mismatch({name, "_cycles"}, 32'(exp_cycles), 32'(cycles));
    assert (low_cycles == exp_cycles)
      else report_mismatch({name, "_strobe"}, 32'(exp_cycles), 32'(low_cycles));
    @(negedge clk_bus);
    bus_req.read  = 1'b0;
    bus_req.write = 1'b0;
  endtask

  initial begin
    bus_data_t rnd;
    bus_data_t rd;
    int        idx;
    rst_n   = 1'b0;
    bus_req = '0;
    repeat (10) begin
      @(posedge clk_bus);
      assert (!bus_rsp.stall) else report_mismatch("reset_stall", 32'd0, 32'(bus_rsp.stall));
    end
    @(negedge clk_bus);
    rst_n = 1'b1;
    @(posedge clk_bus);
    assert (!bus_rsp.stall) else report_mismatch("post_reset_stall", 32'd0, 32'(bus_rsp.stall));

    for (int i = 0; i < n_words; i++) begin
      rnd         = $random(seed);
      word_idx[i] = {rnd[5:0], 4'(i)};  // low bits keep the word addresses distinct.
      flash_ref[i][15:0] = rnd[15:0];
      run_access("flash_wr_lo", make_req(1'b0, i, 4'b0011, rnd, 1'b1), flash_half_cycles, rd);
      rnd = $random(seed);
      flash_ref[i][31:16] = rnd[31:16];
      run_access("flash_wr_hi", make_req(1'b0, i, 4'b1100, rnd, 1'b1), flash_half_cycles, rd);
      @(posedge clk_bus);
      rnd = {u_flash_model.mem[{word_idx[i], 1'b1}], u_flash_model.mem[{word_idx[i], 1'b0}]};
      assert (rnd == flash_ref[i]) else report_mismatch("flash_store", flash_ref[i], rnd);
      run_access("flash_rd_lo", make_req(1'b0, i, 4'b0011, '0, 1'b0), flash_half_cycles, rd);
      assert (rd == {2{flash_ref[i][15:0]}})
        else report_mismatch("flash_rd_lo", {2{flash_ref[i][15:0]}}, rd);
      run_access("flash_rd_hi", make_req(1'b0, i, 4'b1100, '0, 1'b0), flash_half_cycles, rd);
      assert (rd == {2{flash_ref[i][31:16]}})
        else report_mismatch("flash_rd_hi", {2{flash_ref[i][31:16]}}, rd);
    end

    for (int i = 0; i < n_words; i++) begin
      run_access("flash_rd_word", make_req(1'b0, i, 4'b1111, '0, 1'b0), flash_word_cycles, rd);
      assert (rd == flash_ref[i]) else report_mismatch("flash_rd_word", flash_ref[i], rd);
    end

    for (int i = 0; i < n_words; i++) begin
      rnd         = $random(seed);
      sram_ref[i] = rnd;
      run_access("sram_wr", make_req(1'b1, i, 4'b1111, rnd, 1'b1), sram_cycles, rd);
      @(posedge clk_bus);
      assert (u_sram_model.mem[word_idx[i]] == rnd)
        else report_mismatch("sram_store", rnd, u_sram_model.mem[word_idx[i]]);
      run_access("sram_rd", make_req(1'b1, i, 4'b1111, '0, 1'b0), sram_cycles, rd);
      assert (rd == rnd) else report_mismatch("sram_rd", rnd, rd);
    end

    for (int k = 0; k < 32; k++) begin
      rnd = $random(seed);
      idx = rnd % n_words;
      if (k % 2 == 0) begin
        run_access("mixed_flash", make_req(1'b0, idx, 4'b1111, '0, 1'b0), flash_word_cycles, rd);
        assert (rd == flash_ref[idx]) else report_mismatch("mixed_flash", flash_ref[idx], rd);
      end else begin
        run_access("mixed_sram", make_req(1'b1, idx, 4'b1111, '0, 1'b0), sram_cycles, rd);
        assert (rd == sram_ref[idx]) else report_mismatch("mixed_sram", sram_ref[idx], rd);
      end
      repeat (rnd[9:8]) @(negedge clk_bus);  // up to three extra idle cycles.
    end

    $display("All checks passed");
    $finish;
  end

endmodule

// File: ext_mem_top.f
hw/ext_mem_pkg.sv
hw/parallel_ifce.sv
hw/flash_top.sv
hw/bus_decode.sv
hw/ext_mem_top.sv
bench/mem_models.sv
bench/tb_ext_mem.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ext_mem -f ext_mem_top.f -o tb_ext_mem

# the simulator exits non-zero on a failed check, so the log decides the result.
./obj_dir/tb_ext_mem > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
  exit 1
fi
exit 0
